// File: hw/cpu_macros.svh
// CPU core constants
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Bus widths
`define CPU_DATA_W       8
`define CPU_ADDR_W       16

// Reset vector and status reset value (bit 5 always set)
`define CPU_RESET_LO     16'hFFFC
`define CPU_RESET_HI     16'hFFFD
`define CPU_P_RESET      8'h20

// Opcode field values for the absolute ALU group
`define CPU_FAMILY_ALU   2'b01
`define CPU_MODE_ABS     3'b011

// Flag instruction select bits
`define CPU_FI_W         3
`define CPU_FI_CLC       0
`define CPU_FI_SEC       1
`define CPU_FI_CLV       2

// ----------------------------------------
// Opcodes
// ----------------------------------------
`define OP_CLC           8'h18
`define OP_SEC           8'h38
`define OP_CLV           8'hB8
`define OP_NOP           8'hEA
`define OP_LDA_IMM       8'hA9
`define OP_LDX_IMM       8'hA2
`define OP_LDY_IMM       8'hA0
`define OP_JMP_ABS       8'h4C
`define OP_LDA_ABS       8'hAD
`define OP_LDX_ABS       8'hAE
`define OP_LDY_ABS       8'hAC
`define OP_STA_ABS       8'h8D
`define OP_STX_ABS       8'h8E
`define OP_STY_ABS       8'h8C
`define OP_ORA_ABS       8'h0D
`define OP_AND_ABS       8'h2D
`define OP_EOR_ABS       8'h4D
`define OP_ADC_ABS       8'h6D
`define OP_CMP_ABS       8'hCD
`define OP_SBC_ABS       8'hED

`endif

// File: hw/cpu_pkg.sv
// CPU core types
`include "cpu_macros.svh"

package cpu_pkg;

  // ----------------------------------------
  // Opcode views
  // ----------------------------------------

  // Classic aaa-bbb-cc split of a 6502 opcode
  typedef struct packed {
    logic [2:0] group;
    logic [2:0] mode;
    logic [1:0] family;
  } opcode_fields_t;

  typedef union packed {
    logic [`CPU_DATA_W-1:0] raw;
    opcode_fields_t         f;
  } opcode_u;

  // ----------------------------------------
  // Decode results
  // ----------------------------------------
  typedef enum logic [2:0] {
    MODE_IMPLIED,
    MODE_IMMEDIATE,
    MODE_ABSOLUTE,
    MODE_JUMP,
    MODE_ILLEGAL
  } addr_mode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS
  } alu_op_e;

  typedef enum logic [1:0] {
    DEST_NONE,
    DEST_A,
    DEST_X,
    DEST_Y
  } dest_e;

  // Bit positions in P
  typedef enum logic [2:0] {
    FLAG_C = 3'd0,
    FLAG_Z = 3'd1,
    FLAG_V = 3'd6,
    FLAG_N = 3'd7
  } flag_e;

  typedef enum logic [3:0] {
    RESET,
    VEC_LO,
    VEC_HI,
    FETCH,
    DECODE,
    ABS_LO,
    ABS_HI,
    ABS_DATA,
    HALT
  } seq_state_e;

endpackage

// File: hw/cpu_decode.sv
// Instruction decoder
`include "cpu_macros.svh"

module cpu_decode import cpu_pkg::*; (
  input  opcode_u              ir,
  output addr_mode_e           mode,
  output alu_op_e              op,
  output dest_e                dest,
  output dest_e                src,
  output logic [`CPU_FI_W-1:0] sets_flags
);

  always_comb begin
    mode       = MODE_ILLEGAL;
    op         = ALU_PASS;
    dest       = DEST_NONE;
    src        = DEST_NONE;
    sets_flags = '0;

    if (ir.f.family == `CPU_FAMILY_ALU && ir.f.mode == `CPU_MODE_ABS) begin
      // Absolute ALU group, operation picked by aaa
      mode = MODE_ABSOLUTE;
      dest = DEST_A;
      case (ir.f.group)
        3'd0: op = ALU_OR;
        3'd1: op = ALU_AND;
        3'd2: op = ALU_XOR;
        3'd3: op = ALU_ADD;
        3'd4: begin
          dest = DEST_NONE;
          src  = DEST_A;
        end
        3'd5: op = ALU_PASS;
        3'd6: begin
          // CMP keeps A
          op   = ALU_SUB;
          dest = DEST_NONE;
        end
        default: op = ALU_SUB;
      endcase
    end else begin
      case (ir.raw)
        `OP_CLC: begin
          mode = MODE_IMPLIED;
          sets_flags[`CPU_FI_CLC] = 1'b1;
        end
        `OP_SEC: begin
          mode = MODE_IMPLIED;
          sets_flags[`CPU_FI_SEC] = 1'b1;
        end
        `OP_CLV: begin
          mode = MODE_IMPLIED;
          sets_flags[`CPU_FI_CLV] = 1'b1;
        end
        `OP_NOP:     mode = MODE_IMPLIED;
        `OP_JMP_ABS: mode = MODE_JUMP;
        `OP_LDX_IMM: begin
          mode = MODE_IMMEDIATE;
          dest = DEST_X;
        end
        `OP_LDY_IMM: begin
          mode = MODE_IMMEDIATE;
          dest = DEST_Y;
        end
        `OP_LDX_ABS: begin
          mode = MODE_ABSOLUTE;
          dest = DEST_X;
        end
        `OP_LDY_ABS: begin
          mode = MODE_ABSOLUTE;
          dest = DEST_Y;
        end
        `OP_STX_ABS: begin
          mode = MODE_ABSOLUTE;
          src  = DEST_X;
        end
        `OP_STY_ABS: begin
          mode = MODE_ABSOLUTE;
          src  = DEST_Y;
        end
        // LDA immediate sits outside the absolute group
        `OP_LDA_IMM: begin
          mode = MODE_IMMEDIATE;
          dest = DEST_A;
        end
        default: mode = MODE_ILLEGAL;
      endcase
    end
  end

endmodule

// File: hw/cpu_sequencer.sv
// Cycle sequencer and bus control
`include "cpu_macros.svh"

module cpu_sequencer import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`CPU_DATA_W-1:0] rd_data,
  input  logic [`CPU_DATA_W-1:0] store_data,
  input  addr_mode_e            mode,
  input  logic [`CPU_FI_W-1:0]  sets_flags,
  input  dest_e                 src,
  output opcode_u               ir,
  output logic [`CPU_ADDR_W-1:0] address,
  output logic [`CPU_DATA_W-1:0] wr_data,
  output logic                  wr_enable,
  output logic                  sync,
  output logic                  commit
);

  seq_state_e             state;
  logic [`CPU_ADDR_W-1:0] pc;
  logic [`CPU_DATA_W-1:0] lo_q;
  logic [`CPU_DATA_W-1:0] ir_q;
  logic                   is_store;

  // Opcode arrives on rd_data during DECODE
  assign ir       = opcode_u'((state == DECODE) ? rd_data : ir_q);
  assign is_store = (mode == MODE_ABSOLUTE) && (src != DEST_NONE);
  assign wr_data  = store_data;

  // ----------------------------------------
  // Bus outputs
  // ----------------------------------------
  always_comb begin
    address   = pc;
    sync      = 1'b0;
    wr_enable = 1'b0;
    commit    = 1'b0;
    case (state)
      RESET:  address = `CPU_RESET_LO;
      VEC_LO: address = `CPU_RESET_HI;
      VEC_HI: begin
        // First opcode fetch straight from the vector
        address = {rd_data, lo_q};
        sync    = 1'b1;
      end
      FETCH: begin
        sync   = 1'b1;
        commit = (mode == MODE_IMMEDIATE);
      end
      DECODE: commit = (mode == MODE_IMPLIED) && (|sets_flags);
      ABS_HI: begin
        address   = {rd_data, lo_q};
        sync      = (mode == MODE_JUMP);
        wr_enable = is_store;
      end
      ABS_DATA: begin
        sync   = 1'b1;
        commit = 1'b1;
      end
      default: address = pc;
    endcase
  end

  // ----------------------------------------
  // State, PC and operand capture
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= RESET;
      ir_q  <= `OP_NOP;
    end else begin
      case (state)
        RESET:  state <= VEC_LO;
        VEC_LO: begin
          lo_q  <= rd_data;
          state <= VEC_HI;
        end
        VEC_HI: begin
          pc    <= {rd_data, lo_q} + 1'b1;
          state <= DECODE;
        end
        FETCH, ABS_DATA: begin
          pc    <= pc + 1'b1;
          state <= DECODE;
        end
        DECODE: begin
          ir_q <= rd_data;
          case (mode)
            MODE_IMPLIED: state <= FETCH;
            MODE_IMMEDIATE: begin
              pc    <= pc + 1'b1;
              state <= FETCH;
            end
            MODE_ABSOLUTE, MODE_JUMP: begin
              pc    <= pc + 1'b1;
              state <= ABS_LO;
            end
            default: state <= HALT;
          endcase
        end
        ABS_LO: begin
          lo_q  <= rd_data;
          pc    <= pc + 1'b1;
          state <= ABS_HI;
        end
        ABS_HI: begin
          if (mode == MODE_JUMP) begin
            // Target fetch happens in this cycle
            pc    <= {rd_data, lo_q} + 1'b1;
            state <= DECODE;
          end else if (is_store) begin
            state <= FETCH;
          end else begin
            state <= ABS_DATA;
          end
        end
        default: state <= HALT;
      endcase
    end
  end

endmodule

// File: hw/cpu_alu.sv
// 8-bit ALU
`include "cpu_macros.svh"

module cpu_alu import cpu_pkg::*; (
  input  logic [`CPU_DATA_W-1:0] a,
  input  logic [`CPU_DATA_W-1:0] b,
  input  logic                  carry_in,
  input  alu_op_e               op,
  output logic [`CPU_DATA_W-1:0] y,
  output logic                  carry_out,
  output logic                  overflow
);

  localparam int MSB = `CPU_DATA_W - 1;

  logic [`CPU_DATA_W-1:0] b_eff;
  logic [`CPU_DATA_W:0]   sum;

  // Subtract is A + ~M + C
  assign b_eff = (op == ALU_SUB) ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{`CPU_DATA_W{1'b0}}, carry_in};

  always_comb begin
    y         = b;
    carry_out = carry_in;
    overflow  = 1'b0;
    case (op)
      ALU_ADD, ALU_SUB: begin
        y         = sum[MSB:0];
        carry_out = sum[`CPU_DATA_W];
        // Same input signs, different result sign
        overflow  = (a[MSB] == b_eff[MSB]) && (sum[MSB] != a[MSB]);
      end
      ALU_AND: y = a & b;
      ALU_OR:  y = a | b;
      ALU_XOR: y = a ^ b;
      default: y = b;
    endcase
  end

endmodule

// File: hw/cpu_result.sv
// Register file and flag update
`include "cpu_macros.svh"

module cpu_result import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  commit,
  input  logic [`CPU_DATA_W-1:0] operand,
  input  alu_op_e               op,
  input  dest_e                 dest,
  input  dest_e                 src,
  input  logic [`CPU_FI_W-1:0]  sets_flags,
  output logic [`CPU_DATA_W-1:0] alu_a,
  output logic [`CPU_DATA_W-1:0] alu_b,
  output logic                  alu_carry_in,
  output logic [`CPU_DATA_W-1:0] store_data,
  input  logic [`CPU_DATA_W-1:0] alu_y,
  input  logic                  alu_carry,
  input  logic                  alu_overflow
);

  logic [`CPU_DATA_W-1:0] a_q;
  logic [`CPU_DATA_W-1:0] x_q;
  logic [`CPU_DATA_W-1:0] y_q;
  logic [`CPU_DATA_W-1:0] p_q;
  logic                   is_arith;
  logic                   is_cmp;

  assign is_arith = (op == ALU_ADD) || (op == ALU_SUB);
  assign is_cmp   = (op == ALU_SUB) && (dest == DEST_NONE);

  // CMP always subtracts with carry set
  assign alu_a        = a_q;
  assign alu_b        = operand;
  assign alu_carry_in = is_cmp ? 1'b1 : p_q[FLAG_C];

  always_comb begin
    case (src)
      DEST_X:  store_data = x_q;
      DEST_Y:  store_data = y_q;
      default: store_data = a_q;
    endcase
  end

  // ----------------------------------------
  // Commit
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      a_q <= '0;
      x_q <= '0;
      y_q <= '0;
      p_q <= `CPU_P_RESET;
    end else if (commit) begin
      if (|sets_flags) begin
        if (sets_flags[`CPU_FI_CLC]) p_q[FLAG_C] <= 1'b0;
        if (sets_flags[`CPU_FI_SEC]) p_q[FLAG_C] <= 1'b1;
        if (sets_flags[`CPU_FI_CLV]) p_q[FLAG_V] <= 1'b0;
      end else begin
        case (dest)
          DEST_A:  a_q <= alu_y;
          DEST_X:  x_q <= alu_y;
          DEST_Y:  y_q <= alu_y;
          default: a_q <= a_q;
        endcase
        p_q[FLAG_N] <= alu_y[`CPU_DATA_W-1];
        p_q[FLAG_Z] <= ~|alu_y;
        if (is_arith) p_q[FLAG_C] <= alu_carry;
        // V only from ADC and SBC
        if (is_arith && !is_cmp) p_q[FLAG_V] <= alu_overflow;
      end
    end
  end

endmodule

// File: hw/cpu_top.sv
// CPU core top level
`include "cpu_macros.svh"

module cpu_top import cpu_pkg::*; (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic [`CPU_DATA_W-1:0] rd_data,
  output logic [`CPU_ADDR_W-1:0] address,
  output logic [`CPU_DATA_W-1:0] wr_data,
  output logic                  wr_enable,
  output logic                  sync
);

  opcode_u                ir;
  addr_mode_e             mode;
  alu_op_e                op;
  dest_e                  dest;
  dest_e                  src;
  logic [`CPU_FI_W-1:0]   sets_flags;
  logic                   commit;
  logic [`CPU_DATA_W-1:0] store_data;
  logic [`CPU_DATA_W-1:0] alu_a;
  logic [`CPU_DATA_W-1:0] alu_b;
  logic [`CPU_DATA_W-1:0] alu_y;
  logic                   alu_carry_in;
  logic                   alu_carry;
  logic                   alu_overflow;

  cpu_sequencer seq_i (
    .clk        (clk),
    .resetn     (resetn),
    .rd_data    (rd_data),
    .store_data (store_data),
    .mode       (mode),
    .sets_flags (sets_flags),
    .src        (src),
    .ir         (ir),
    .address    (address),
    .wr_data    (wr_data),
    .wr_enable  (wr_enable),
    .sync       (sync),
    .commit     (commit)
  );

  cpu_decode dec_i (
    .ir         (ir),
    .mode       (mode),
    .op         (op),
    .dest       (dest),
    .src        (src),
    .sets_flags (sets_flags)
  );

  cpu_alu alu_i (
    .a         (alu_a),
    .b         (alu_b),
    .carry_in  (alu_carry_in),
    .op        (op),
    .y         (alu_y),
    .carry_out (alu_carry),
    .overflow  (alu_overflow)
  );

  // Operand is whatever the memory returns in the commit cycle
  cpu_result res_i (
    .clk          (clk),
    .resetn       (resetn),
    .commit       (commit),
    .operand      (rd_data),
    .op           (op),
    .dest         (dest),
    .src          (src),
    .sets_flags   (sets_flags),
    .alu_a        (alu_a),
    .alu_b        (alu_b),
    .alu_carry_in (alu_carry_in),
    .store_data   (store_data),
    .alu_y        (alu_y),
    .alu_carry    (alu_carry),
    .alu_overflow (alu_overflow)
  );

endmodule

// File: bench/cpu_properties.sv
// CPU bus assertions
`include "cpu_macros.svh"

module cpu_properties (
  input logic                   clk,
  input logic                   resetn,
  input logic [`CPU_ADDR_W-1:0] address,
  input logic                   wr_enable,
  input logic                   sync
);
  timeunit 1ns;
  timeprecision 100ps;

  // One cycle after reset is seen, the vector low byte is on the bus
  property p_reset_address;
    @(posedge clk) !resetn ##1 !resetn |-> address == `CPU_RESET_LO;
  endproperty

  property p_no_sync_write;
    @(posedge clk) disable iff (!resetn) !(sync && wr_enable);
  endproperty

  // Stores write for one cycle only
  property p_single_write;
    @(posedge clk) disable iff (!resetn) wr_enable |=> !wr_enable;
  endproperty

  a_reset_address: assert property (p_reset_address)
    else $error("address left the reset vector while in reset");
  a_no_sync_write: assert property (p_no_sync_write)
    else $error("sync and wr_enable high in the same cycle");
  a_single_write: assert property (p_single_write)
    else $error("wr_enable held for more than one cycle");

endmodule

// File: bench/cpu_tb.sv
// CPU core testbench
`include "cpu_macros.svh"

module cpu_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_TESTS       = 16;
  localparam int PROG_MAX      = 16;
  localparam int STORE_TIMEOUT = 100;
  localparam int WATCHDOG_NS   = N_TESTS * 200 * 4;

  logic                   clk;
  logic                   resetn;
  logic [`CPU_DATA_W-1:0] rd_data;
  logic [`CPU_ADDR_W-1:0] address;
  logic [`CPU_DATA_W-1:0] wr_data;
  logic                   wr_enable;
  logic                   sync;

  logic [7:0]  mem [0:65535];
  logic [15:0] addr_q;
  logic        got_store;
  logic [7:0]  store_val;
  logic        got_fetch;
  logic [15:0] fetch_addr;

  // Test table
  string                 t_name [N_TESTS];
  logic [8*PROG_MAX-1:0] t_prog [N_TESTS];
  int                    t_len  [N_TESTS];
  logic [7:0]            t_d0   [N_TESTS];
  logic [7:0]            t_d1   [N_TESTS];
  logic [7:0]            t_exp  [N_TESTS];
  int                    n_tests;
  int                    pass_count;
  int                    fail_count;

  cpu_top dut_i (
    .clk       (clk),
    .resetn    (resetn),
    .rd_data   (rd_data),
    .address   (address),
    .wr_data   (wr_data),
    .wr_enable (wr_enable),
    .sync      (sync)
  );

  bind cpu_top cpu_properties props_i (
    .clk       (clk),
    .resetn    (resetn),
    .address   (address),
    .wr_enable (wr_enable),
    .sync      (sync)
  );

  always #2 clk = ~clk;

  // ----------------------------------------
  // Memory model
  // ----------------------------------------
  always @(posedge clk) begin
    addr_q = address;
    // First opcode fetch after reset
    if (sync && !got_fetch) begin
      got_fetch  = 1'b1;
      fetch_addr = address;
    end
    if (wr_enable) begin
      mem[address] = wr_data;
      if (address == 16'h0300 && !got_store) begin
        got_store = 1'b1;
        store_val = wr_data;
      end
    end
  end

  // Read data for the previous address, driven mid-cycle
  always @(negedge clk) begin
    rd_data = mem[addr_q];
  end

  function automatic logic [7:0] fill_byte(input logic [15:0] a);
    return a[7:0] ^ a[15:8] ^ 8'hA5;
  endfunction

  task automatic add_test(input string name, input logic [8*PROG_MAX-1:0] prog,
                          input int len, input logic [7:0] d0, input logic [7:0] d1,
                          input logic [7:0] exp);
    t_name[n_tests] = name;
    t_prog[n_tests] = prog;
    t_len[n_tests]  = len;
    t_d0[n_tests]   = d0;
    t_d1[n_tests]   = d1;
    t_exp[n_tests]  = exp;
    n_tests++;
  endtask

  // Program at 0200 closed by a JMP to itself
  task automatic load_memory(input int idx);
    int   a;
    logic [15:0] loop_at;
    for (a = 0; a < 65536; a++) begin
      mem[a] = fill_byte(a[15:0]);
    end
    mem[`CPU_RESET_LO] = 8'h00;
    mem[`CPU_RESET_HI] = 8'h02;
    for (a = 0; a < t_len[idx]; a++) begin
      mem[16'h0200 + a] = t_prog[idx][8*(t_len[idx]-1-a) +: 8];
    end
    loop_at = 16'h0200 + t_len[idx];
    mem[loop_at]     = `OP_JMP_ABS;
    mem[loop_at + 1] = loop_at[7:0];
    mem[loop_at + 2] = loop_at[15:8];
    mem[16'h0310] = t_d0[idx];
    mem[16'h0311] = t_d1[idx];
  endtask

  task automatic run_test(input int idx);
    int cycles;
    cycles = 0;
    @(negedge clk);
    resetn = 1'b0;
    @(negedge clk);
    load_memory(idx);
    repeat (3) @(negedge clk);
    got_store = 1'b0;
    got_fetch = 1'b0;
    resetn    = 1'b1;
    while (!got_store && cycles < STORE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!got_store) begin
      $display("test %0d %s: no store to 0300 seen", idx, t_name[idx]);
      fail_count++;
    end else if (!got_fetch) begin
      $display("test %0d %s: no opcode fetch with sync seen", idx, t_name[idx]);
      fail_count++;
    end else if (fetch_addr !== 16'h0200) begin
      $display("ERR test %0d %s: address at first sync expected %04h got %04h",
               idx, t_name[idx], 16'h0200, fetch_addr);
      fail_count++;
    end else if (store_val !== t_exp[idx]) begin
      $display("ERR test %0d %s: wr_data expected %02h got %02h",
               idx, t_name[idx], t_exp[idx], store_val);
      fail_count++;
    end else begin
      $display("test %0d %s ok, wr_data %02h", idx, t_name[idx], store_val);
      pass_count++;
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  // ----------------------------------------
  // Table and main loop
  // ----------------------------------------
  initial begin
    clk        = 1'b0;
    resetn     = 1'b0;
    rd_data    = '0;
    got_store  = 1'b0;
    store_val  = '0;
    got_fetch  = 1'b0;
    fetch_addr = '0;
    addr_q     = `CPU_RESET_LO;
    n_tests    = 0;
    pass_count = 0;
    fail_count = 0;

    add_test("lda_imm", {`OP_LDA_IMM, 8'h5A, `OP_STA_ABS, 8'h00, 8'h03}, 5, 8'h00, 8'h00, 8'h5A);
    add_test("ldx_abs", {`OP_LDX_ABS, 8'h10, 8'h03, `OP_STX_ABS, 8'h00, 8'h03},
             6, 8'h9C, 8'h00, 8'h9C);
    add_test("ldy_abs", {`OP_LDY_ABS, 8'h11, 8'h03, `OP_STY_ABS, 8'h00, 8'h03},
             6, 8'h00, 8'hE1, 8'hE1);
    add_test("ldx_imm", {`OP_LDX_IMM, 8'h3E, `OP_STX_ABS, 8'h00, 8'h03}, 5, 8'h00, 8'h00, 8'h3E);
    add_test("ldy_imm_nop", {`OP_LDY_IMM, 8'h77, `OP_NOP, `OP_STY_ABS, 8'h00, 8'h03},
             6, 8'h00, 8'h00, 8'h77);
    add_test("sbc_abs", {`OP_SEC, `OP_LDA_ABS, 8'h10, 8'h03, `OP_SBC_ABS, 8'h11, 8'h03,
             `OP_STA_ABS, 8'h00, 8'h03}, 10, 8'h50, 8'h23, 8'h50 - 8'h23);
    add_test("adc_abs", {`OP_CLC, `OP_LDA_ABS, 8'h10, 8'h03, `OP_ADC_ABS, 8'h11, 8'h03,
             `OP_STA_ABS, 8'h00, 8'h03}, 10, 8'hC8, 8'h64, 8'hC8 + 8'h64);
    add_test("and_abs", {`OP_LDA_ABS, 8'h10, 8'h03, `OP_AND_ABS, 8'h11, 8'h03,
             `OP_STA_ABS, 8'h00, 8'h03}, 9, 8'hA5, 8'h3C, 8'hA5 & 8'h3C);
    add_test("ora_abs", {`OP_LDA_ABS, 8'h10, 8'h03, `OP_ORA_ABS, 8'h11, 8'h03,
             `OP_STA_ABS, 8'h00, 8'h03}, 9, 8'hA5, 8'h3C, 8'hA5 | 8'h3C);
    add_test("eor_abs", {`OP_LDA_ABS, 8'h10, 8'h03, `OP_EOR_ABS, 8'h11, 8'h03,
             `OP_STA_ABS, 8'h00, 8'h03}, 9, 8'hA5, 8'h3C, 8'hA5 ^ 8'h3C);
    // FF + 01 leaves C set, so 00 + 00 + C gives 01
    add_test("carry_out", {`OP_CLC, `OP_LDA_IMM, 8'hFF, `OP_ADC_ABS, 8'h10, 8'h03,
             `OP_LDA_IMM, 8'h00, `OP_ADC_ABS, 8'h11, 8'h03, `OP_STA_ABS, 8'h00, 8'h03},
             14, 8'h01, 8'h00, 8'h01);
    // CLV must keep the carry from SEC
    add_test("clv_keeps_c", {`OP_SEC, `OP_LDA_IMM, 8'h10, `OP_CLV, `OP_ADC_ABS, 8'h10, 8'h03,
             `OP_STA_ABS, 8'h00, 8'h03}, 10, 8'h05, 8'h00, 8'h10 + 8'h05 + 8'h01);
    add_test("cmp_keeps_a", {`OP_LDA_IMM, 8'h42, `OP_CMP_ABS, 8'h10, 8'h03,
             `OP_STA_ABS, 8'h00, 8'h03}, 8, 8'h42, 8'h00, 8'h42);
    add_test("cmp_equal", {`OP_LDA_IMM, 8'h42, `OP_CMP_ABS, 8'h10, 8'h03, `OP_LDA_IMM, 8'h00,
             `OP_ADC_ABS, 8'h11, 8'h03, `OP_STA_ABS, 8'h00, 8'h03}, 13, 8'h42, 8'h00, 8'h01);
    add_test("cmp_larger", {`OP_LDA_IMM, 8'h42, `OP_CMP_ABS, 8'h10, 8'h03, `OP_LDA_IMM, 8'h00,
             `OP_ADC_ABS, 8'h11, 8'h03, `OP_STA_ABS, 8'h00, 8'h03}, 13, 8'h50, 8'h00, 8'h00);
    // JMP 020A skips LDA #EE and the store at 0207
    add_test("jmp_abs", {`OP_LDA_IMM, 8'h33, `OP_JMP_ABS, 8'h0A, 8'h02, `OP_LDA_IMM, 8'hEE,
             `OP_STA_ABS, 8'h00, 8'h03, `OP_STA_ABS, 8'h00, 8'h03}, 13, 8'h00, 8'h00, 8'h33);

    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end

    $display("tests %0d, passed %0d, failed %0d", n_tests, pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_decode.sv
hw/cpu_sequencer.sv
hw/cpu_alu.sv
hw/cpu_result.sv
hw/cpu_top.sv
bench/cpu_properties.sv
bench/cpu_tb.sv
